//--- list.f
mc_rw_pkg.sv
mc_wtr_timer.sv
mc_rtw_timer.sv
mc_rw_starve.sv
mc_rw_turnaround.sv
tb_clk_gen.sv
mc_rw_checker.sv
mc_rw_monitor.sv
mc_rw_tb.sv

//--- mc_rtw_timer.sv
/*
 * read-to-write turnaround counter
 * loads on every read CAS and masks all write requests until the
 * counter drains, also masks writes in the read CAS cycle itself
 */

`timescale 1ns/10ps

module mc_rtw_timer #(
  parameter int T_RTW = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rd_cas,
  // write requests after the starvation gate
  input  mc_rw_pkg::slot_vec_t wr_req,
  output mc_rw_pkg::slot_vec_t wr_permit
);

  import mc_rw_pkg::*;

  // counter load in fabric cycles, zero with the default tRTW
  localparam int RTW_LOAD = rtw_cycles(T_RTW);
  localparam int CNT_W = (RTW_LOAD > 0) ? $clog2(RTW_LOAD + 1) : 1;

  logic [CNT_W-1:0] rtw_cnt;
  logic             rtw_ok;

  // ----------------------------------------------------------------------
  // turnaround countdown
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst) begin
      rtw_cnt <= '0;
    end else if (rd_cas) begin
      // read CAS restarts the window
      rtw_cnt <= CNT_W'(RTW_LOAD);
    end else if (rtw_cnt != '0) begin
      rtw_cnt <= rtw_cnt - 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // write gate
  // ----------------------------------------------------------------------

  // window drained and no read on the bus this cycle
  assign rtw_ok = (rtw_cnt == '0) && !rd_cas;

  // same gate for every slot
  assign wr_permit = wr_req & {NUM_SLOTS{rtw_ok}};

endmodule

//--- mc_rw_checker.sv
/*
 * turnaround gate assertions, bound into the top level
 * same-cycle write-to-read, read CAS against write permits
 * and permits without a request
 */

`timescale 1ns/10ps

module mc_rw_checker #(
  // rank select width, four ranks
  parameter int RK_W = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  mc_rw_pkg::slot_vec_t rd_req,
  input  mc_rw_pkg::slot_vec_t wr_req,
  input  logic [RK_W-1:0]      cmd_rank [mc_rw_pkg::NUM_SLOTS],
  input  logic                 rd_cas,
  input  logic                 wr_cas,
  input  logic [RK_W-1:0]      win_rank,
  input  mc_rw_pkg::slot_vec_t rd_permit,
  input  mc_rw_pkg::slot_vec_t wr_permit
);

  import mc_rw_pkg::*;

  // a write CAS closes its rank to reads in the same cycle
  for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
    a_wtr_same_cycle: assert property (@(posedge clk) disable iff (!rst)
      !(wr_cas && rd_permit[i] && (cmd_rank[i] == win_rank)))
      else $error("read permit on slot %0d to the rank of a write CAS", i);
  end

  // read CAS on the bus, no write may go
  a_rtw_cas: assert property (@(posedge clk) disable iff (!rst)
    !(rd_cas && (wr_permit != '0)))
    else $error("write permit given in a read CAS cycle");

  // permits only ever narrow the requests
  a_rd_no_req: assert property (@(posedge clk) disable iff (!rst)
    (rd_permit & ~rd_req) == '0)
    else $error("read permit without a read request");

  a_wr_no_req: assert property (@(posedge clk) disable iff (!rst)
    (wr_permit & ~wr_req) == '0)
    else $error("write permit without a write request");

endmodule

//--- mc_rw_monitor.sv
/*
 * reference model and comparator for the turnaround gate
 * models tWTR per rank, tRTW and the starvation counters,
 * compares both permit vectors on every falling edge
 */

`timescale 1ns/10ps

module mc_rw_monitor #(
  parameter int NUM_RANKS = 4,
  parameter int T_WTR_L   = 9,
  parameter int T_WTR_S   = 3,
  parameter int T_RTW     = 4,
  parameter int STARVE_W  = 9,
  parameter bit STARVE_EN = 1'b1,
  parameter int RK_W      = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  mc_rw_pkg::slot_vec_t rd_req,
  input  mc_rw_pkg::slot_vec_t wr_req,
  input  mc_rw_pkg::bg_t       cmd_group [mc_rw_pkg::NUM_SLOTS],
  input  logic [RK_W-1:0]      cmd_rank [mc_rw_pkg::NUM_SLOTS],
  input  logic                 rd_cas,
  input  logic                 wr_cas,
  input  mc_rw_pkg::bg_t       win_group,
  input  logic [RK_W-1:0]      win_rank,
  input  mc_rw_pkg::slot_vec_t rd_permit,
  input  mc_rw_pkg::slot_vec_t wr_permit,
  output int                   rd_errs,
  output int                   wr_errs,
  output int                   checks
);

  import mc_rw_pkg::*;

  // windows in fabric cycles with tCK rounded up
  localparam int WTR_L_CYC = (T_WTR_L + CK_RATIO - 1) / CK_RATIO;
  localparam int WTR_S_CYC = (T_WTR_S + CK_RATIO - 1) / CK_RATIO;
  // rtw load is the floor of (tRTW + 5) / 4 less two and never negative
  localparam int RTW_RAW = (T_RTW + 5) / CK_RATIO - 2;
  localparam int RTW_CYC = (RTW_RAW > 0) ? RTW_RAW : 0;
  localparam int AGE_MAX = (1 << STARVE_W) - 1;

  int        wtr_long [NUM_RANKS];
  int        wtr_short [NUM_RANKS];
  bg_t       grp_last [NUM_RANKS];
  int        rtw_left;
  // registered requests and per-slot ages
  slot_vec_t rq_rd;
  slot_vec_t rq_wr;
  int        age_rd [NUM_SLOTS];
  int        age_wr [NUM_SLOTS];
  slot_vec_t stv_rd;
  slot_vec_t stv_wr;
  logic      blk_rd;
  logic      blk_wr;

  // ----------------------------------------------------------------------
  // model state advanced on the rising edge
  // ----------------------------------------------------------------------

  always @(posedge clk) begin : model_step
    int nxt_rd;
    int nxt_wr;
    if (!rst) begin
      for (int r = 0; r < NUM_RANKS; r++) begin
        wtr_long[r]  <= 0;
        wtr_short[r] <= 0;
        grp_last[r]  <= '0;
      end
      for (int s = 0; s < NUM_SLOTS; s++) begin
        age_rd[s] <= 0;
        age_wr[s] <= 0;
      end
      rtw_left <= 0;
      rq_rd    <= '0;
      rq_wr    <= '0;
      stv_rd   <= '0;
      stv_wr   <= '0;
      blk_rd   <= 1'b0;
      blk_wr   <= 1'b0;
    end else begin
      // write to a rank restarts both of its windows
      for (int r = 0; r < NUM_RANKS; r++) begin
        if (wr_cas && (win_rank == RK_W'(r))) begin
          wtr_long[r]  <= WTR_L_CYC;
          wtr_short[r] <= WTR_S_CYC;
          grp_last[r]  <= win_group;
        end else begin
          wtr_long[r]  <= (wtr_long[r] > 0) ? wtr_long[r] - 1 : 0;
          wtr_short[r] <= (wtr_short[r] > 0) ? wtr_short[r] - 1 : 0;
        end
      end
      rtw_left <= rd_cas ? RTW_CYC : ((rtw_left > 0) ? rtw_left - 1 : 0);
      // age grows while pending and not yet starved and drops to zero when idle
      for (int s = 0; s < NUM_SLOTS; s++) begin
        nxt_rd = rq_rd[s] ? (stv_rd[s] ? age_rd[s] : age_rd[s] + 1) : 0;
        nxt_wr = rq_wr[s] ? (stv_wr[s] ? age_wr[s] : age_wr[s] + 1) : 0;
        age_rd[s] <= nxt_rd;
        age_wr[s] <= nxt_wr;
        stv_rd[s] <= (nxt_rd >= AGE_MAX);
        stv_wr[s] <= (nxt_wr >= AGE_MAX);
      end
      blk_wr <= |stv_rd;
      blk_rd <= |stv_wr;
      // both sides blocked drops every request for one cycle
      rq_rd <= (blk_rd && blk_wr) ? '0 : rd_req;
      rq_wr <= (blk_rd && blk_wr) ? '0 : wr_req;
    end
  end

  // ----------------------------------------------------------------------
  // comparison mid-cycle where the permits are settled
  // ----------------------------------------------------------------------

  always @(negedge clk) begin : compare
    slot_vec_t       rd_ok;
    slot_vec_t       wr_ok;
    slot_vec_t       exp_rd;
    slot_vec_t       exp_wr;
    logic [RK_W-1:0] rk;
    logic            wtr_free;
    if (!rst) begin
      rd_errs <= 0;
      wr_errs <= 0;
      checks  <= 0;
    end else begin
      rd_ok = STARVE_EN ? (rd_req & ~{NUM_SLOTS{blk_rd}}) : rd_req;
      wr_ok = STARVE_EN ? (wr_req & ~{NUM_SLOTS{blk_wr}}) : wr_req;
      for (int i = 0; i < NUM_SLOTS; i++) begin
        rk = cmd_rank[i];
        // same group waits out the long window
        if (grp_last[rk] == cmd_group[i]) begin
          wtr_free = (wtr_long[rk] == 0);
        end else begin
          wtr_free = (wtr_short[rk] == 0);
        end
        exp_rd[i] = rd_ok[i] && wtr_free && !(wr_cas && (win_rank == rk));
      end
      exp_wr = ((rtw_left == 0) && !rd_cas) ? wr_ok : '0;
      checks <= checks + 1;
      if (rd_permit !== exp_rd) begin
        rd_errs <= rd_errs + 1;
        $display("mismatch at %0d ns: rd_permit %b, expected %b", $time, rd_permit, exp_rd);
      end
      if (wr_permit !== exp_wr) begin
        wr_errs <= wr_errs + 1;
        $display("mismatch at %0d ns: wr_permit %b, expected %b", $time, wr_permit, exp_wr);
      end
    end
  end

endmodule

//--- mc_rw_pkg.sv
/*
 * DDR4 read/write turnaround shared definitions
 * slot and bank-group types, fabric clock ratio and the
 * tCK to fabric-cycle conversions used by the turnaround timers
 */

package mc_rw_pkg;

  // ----------------------------------------------------------------------
  // scheduler geometry
  // ----------------------------------------------------------------------

  // one command slot per group FSM
  localparam int NUM_SLOTS = 4;
  // bank-group index width for DDR4
  localparam int BG_BITS = 2;
  // DRAM clocks per fabric clock
  localparam int CK_RATIO = 4;

  // one bit per slot, used for requests, permits and starve flags
  typedef logic [NUM_SLOTS-1:0] slot_vec_t;
  // bank-group index
  typedef logic [BG_BITS-1:0] bg_t;

  // ----------------------------------------------------------------------
  // timing conversions
  // ----------------------------------------------------------------------

  // tCK count rounded up to whole fabric cycles
  function automatic int ck_to_fabric(input int tck);
    return (tck + CK_RATIO - 1) / CK_RATIO;
  endfunction

  // RTW counter load in fabric cycles
  // +5 tCK covers rounding down and the CAS slot position,
  // -2 fabric cycles covers the scheduler pipeline
  function automatic int rtw_cycles(input int t_rtw);
    int fab;
    fab = (t_rtw + 5) / CK_RATIO;
    if (fab - 2 > 0) begin
      return fab - 2;
    end
    return 0;
  endfunction

endpackage

//--- mc_rw_starve.sv
/*
 * read/write starvation guard
 * per-slot saturating counters on both directions, block flags
 * against the opposite direction and a deadlock clear
 */

`timescale 1ns/10ps

module mc_rw_starve #(
  parameter int STARVE_W  = 9,
  parameter bit STARVE_EN = 1'b1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  mc_rw_pkg::slot_vec_t rd_req,
  input  mc_rw_pkg::slot_vec_t wr_req,
  output mc_rw_pkg::slot_vec_t rd_req_ok,
  output mc_rw_pkg::slot_vec_t wr_req_ok
);

  import mc_rw_pkg::*;

  // direction index into the per-direction arrays
  localparam int RD = 0;
  localparam int WR = 1;

  // raw requests by direction
  slot_vec_t req_in [2];
  // registered requests that feed the counters
  slot_vec_t req_ff [2];
  slot_vec_t starve [2];
  slot_vec_t starve_nxt [2];

  logic [STARVE_W-1:0] cnt [2][NUM_SLOTS];
  logic [STARVE_W-1:0] cnt_nxt [2][NUM_SLOTS];

  // block_rd set by a starving write slot, block_wr by a starving read slot
  logic block_rd;
  logic block_wr;
  logic deadlock;

  assign req_in[RD] = rd_req;
  assign req_in[WR] = wr_req;

  // both sides blocked means nothing could ever issue
  assign deadlock = block_rd & block_wr;

  // ----------------------------------------------------------------------
  // saturating counters
  // ----------------------------------------------------------------------

  always_comb begin
    for (int d = 0; d < 2; d++) begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
        // count while pending, stop once starved, clear on idle
        if (req_ff[d][s]) begin
          cnt_nxt[d][s] = cnt[d][s] + STARVE_W'(!starve[d][s]);
        end else begin
          cnt_nxt[d][s] = '0;
        end
        // starve when the next value reaches all-ones
        starve_nxt[d][s] = &cnt_nxt[d][s];
      end
    end
  end

  // ----------------------------------------------------------------------
  // state flops
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int d = 0; d < 2; d++) begin
        req_ff[d] <= '0;
        starve[d] <= '0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
          cnt[d][s] <= '0;
        end
      end
      block_rd <= 1'b0;
      block_wr <= 1'b0;
    end else begin
      for (int d = 0; d < 2; d++) begin
        // forcing requests low on deadlock drains every counter
        req_ff[d] <= req_in[d] & ~{NUM_SLOTS{deadlock}};
        starve[d] <= starve_nxt[d];
        for (int s = 0; s < NUM_SLOTS; s++) begin
          cnt[d][s] <= cnt_nxt[d][s];
        end
      end
      // any starving slot blocks the opposite direction
      block_rd <= |starve[WR];
      block_wr <= |starve[RD];
    end
  end

  // ----------------------------------------------------------------------
  // gated requests
  // ----------------------------------------------------------------------

  // guard disabled gives a straight pass-through
  assign rd_req_ok = STARVE_EN ? (rd_req & ~{NUM_SLOTS{block_rd}}) : rd_req;
  assign wr_req_ok = STARVE_EN ? (wr_req & ~{NUM_SLOTS{block_wr}}) : wr_req;

endmodule

//--- mc_rw_tb.sv
/*
 * testbench for the read/write turnaround gate
 * directed stimulus table, deadlock waits and an LCG random phase
 */

`timescale 1ns/10ps

module mc_rw_tb;

  import mc_rw_pkg::*;

  localparam int NUM_ROWS = 12;

  // one stimulus row with slot 0 in the low bits of grp and rank
  typedef struct packed {
    logic [3:0] rd;
    logic [3:0] wr;
    logic [7:0] grp;
    logic [7:0] rank;
    logic       rc;
    logic       wc;
    logic [1:0] wrk;
    logic [1:0] wgp;
    logic [7:0] hold;
  } row_t;

  logic        clk;
  logic        rst;
  slot_vec_t   rd_req;
  slot_vec_t   wr_req;
  bg_t         cmd_group [NUM_SLOTS];
  logic [1:0]  cmd_rank [NUM_SLOTS];
  logic        rd_cas;
  logic        wr_cas;
  bg_t         win_group;
  logic [1:0]  win_rank;
  slot_vec_t   rd_permit;
  slot_vec_t   wr_permit;
  int          rd_errs;
  int          wr_errs;
  int          checks;
  int          timeouts;
  row_t        stim [NUM_ROWS];
  logic [31:0] seed;

  tb_clk_gen u_clk (.clk (clk), .rst (rst));

  mc_rw_turnaround #(
    .NUM_RANKS (4), .T_WTR_L (9), .T_WTR_S (3), .T_RTW (13), .STARVE_W (4), .STARVE_EN (1'b1)
  ) mc_rw_turnaround_i (
    .clk (clk), .rst (rst), .rd_req (rd_req), .wr_req (wr_req),
    .cmd_group (cmd_group), .cmd_rank (cmd_rank), .rd_cas (rd_cas), .wr_cas (wr_cas),
    .win_group (win_group), .win_rank (win_rank),
    .rd_permit (rd_permit), .wr_permit (wr_permit)
  );

  mc_rw_monitor #(
    .NUM_RANKS (4), .T_WTR_L (9), .T_WTR_S (3), .T_RTW (13), .STARVE_W (4), .STARVE_EN (1'b1)
  ) u_monitor (
    .clk (clk), .rst (rst), .rd_req (rd_req), .wr_req (wr_req),
    .cmd_group (cmd_group), .cmd_rank (cmd_rank), .rd_cas (rd_cas), .wr_cas (wr_cas),
    .win_group (win_group), .win_rank (win_rank), .rd_permit (rd_permit),
    .wr_permit (wr_permit), .rd_errs (rd_errs), .wr_errs (wr_errs), .checks (checks)
  );

  bind mc_rw_turnaround mc_rw_checker u_checker (
    .clk (clk), .rst (rst), .rd_req (rd_req), .wr_req (wr_req), .cmd_rank (cmd_rank),
    .rd_cas (rd_cas), .wr_cas (wr_cas), .win_rank (win_rank),
    .rd_permit (rd_permit), .wr_permit (wr_permit)
  );

  function automatic row_t mk_row(input logic [3:0] rd, input logic [3:0] wr,
                                  input logic [7:0] grp, input logic [7:0] rank,
                                  input logic rc, input logic wc, input logic [1:0] wrk,
                                  input logic [1:0] wgp, input int hold);
    row_t r;
    r = '{rd: rd, wr: wr, grp: grp, rank: rank, rc: rc, wc: wc, wrk: wrk, wgp: wgp,
          hold: 8'(hold)};
    return r;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // drive a row whose CAS strobes last one cycle and whose requests hold for the row
  task automatic apply_row(input row_t r);
    @(posedge clk);
    rd_req <= r.rd;
    wr_req <= r.wr;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      cmd_group[i] <= r.grp[2*i +: 2];
      cmd_rank[i]  <= r.rank[2*i +: 2];
    end
    rd_cas    <= r.rc;
    wr_cas    <= r.wc;
    win_rank  <= r.wrk;
    win_group <= r.wgp;
    for (int k = 1; k < int'(r.hold); k++) begin
      @(posedge clk);
      rd_cas <= 1'b0;
      wr_cas <= 1'b0;
    end
  endtask

  // wait until any permit is high (want_any) or all are low
  task automatic wait_permits(input bit want_any, input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while ((((|rd_permit) || (|wr_permit)) != want_any) && (n < limit)) begin
      @(negedge clk);
      n++;
    end
    if (((|rd_permit) || (|wr_permit)) != want_any) begin
      timeouts++;
      $display("timeout: %s not seen within %0d cycles", what, limit);
    end
  endtask

  initial begin
    rd_req    = '0;
    wr_req    = '0;
    rd_cas    = 1'b0;
    wr_cas    = 1'b0;
    win_group = '0;
    win_rank  = '0;
    timeouts  = 0;
    seed      = 32'h5a34;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      cmd_group[i] = '0;
      cmd_rank[i]  = '0;
    end
    // rd    wr    grp    rank   rcas  wcas  wrank wgrp  hold
    stim[0]  = mk_row(4'h0, 4'h0, 8'h00, 8'h00, 1'b0, 1'b0, 2'd0, 2'd0, 2);
    // write CAS rank 1 group 2 then reads to the same group, another group and another rank
    stim[1]  = mk_row(4'h0, 4'h0, 8'h00, 8'h00, 1'b0, 1'b1, 2'd1, 2'd2, 1);
    stim[2]  = mk_row(4'h7, 4'h0, 8'h22, 8'h35, 1'b0, 1'b0, 2'd0, 2'd0, 6);
    stim[3]  = mk_row(4'h0, 4'h0, 8'h00, 8'h00, 1'b0, 1'b0, 2'd0, 2'd0, 2);
    // read CAS against all write slots
    stim[4]  = mk_row(4'h0, 4'hf, 8'h00, 8'h00, 1'b1, 1'b0, 2'd0, 2'd0, 5);
    stim[5]  = mk_row(4'h0, 4'h0, 8'h00, 8'h00, 1'b0, 1'b0, 2'd0, 2'd0, 2);
    // read starves while a later write is pending
    stim[6]  = mk_row(4'h1, 4'h0, 8'h00, 8'h00, 1'b0, 1'b0, 2'd0, 2'd0, 4);
    stim[7]  = mk_row(4'h1, 4'h2, 8'h00, 8'h00, 1'b0, 1'b0, 2'd0, 2'd0, 14);
    stim[8]  = mk_row(4'h0, 4'h2, 8'h00, 8'h00, 1'b0, 1'b0, 2'd0, 2'd0, 6);
    stim[9]  = mk_row(4'h0, 4'h0, 8'h00, 8'h00, 1'b0, 1'b0, 2'd0, 2'd0, 4);
    // write CAS to rank 2 while slot 0 reads rank 2
    stim[10] = mk_row(4'h3, 4'h0, 8'h04, 8'h02, 1'b0, 1'b1, 2'd2, 2'd1, 3);
    stim[11] = mk_row(4'h0, 4'h0, 8'h00, 8'h00, 1'b0, 1'b0, 2'd0, 2'd0, 3);

    for (int n = 0; (n < 20) && !rst; n++) begin
      @(posedge clk);
    end
    if (!rst) begin
      timeouts++;
      $display("timeout: reset was never released");
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(stim[r]);
    end

    // reads and writes held together until both sides block and then clear
    apply_row(mk_row(4'h4, 4'h8, 8'h00, 8'h00, 1'b0, 1'b0, 2'd0, 2'd0, 1));
    wait_permits(1'b0, 40, "deadlock block");
    wait_permits(1'b1, 40, "deadlock recovery");
    apply_row(stim[11]);

    // random phase with sparse CAS strobes
    for (int c = 0; c < 200; c++) begin
      @(posedge clk);
      seed = lcg_next(seed);
      rd_req    <= seed[19:16];
      wr_req    <= seed[23:20];
      rd_cas    <= (seed[25:24] == 2'd0);
      wr_cas    <= (seed[27:26] == 2'd0);
      win_rank  <= seed[29:28];
      win_group <= seed[31:30];
      seed = lcg_next(seed);
      for (int i = 0; i < NUM_SLOTS; i++) begin
        cmd_group[i] <= seed[16 + 4*i +: 2];
        cmd_rank[i]  <= seed[18 + 4*i +: 2];
      end
    end
    apply_row(stim[11]);

    $display("rd_permit errors %0d, wr_permit errors %0d, timeouts %0d, cycles checked %0d",
             rd_errs, wr_errs, timeouts, checks);
    if ((rd_errs + wr_errs + timeouts) == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- mc_rw_turnaround.sv
/*
 * DDR4 scheduler read/write turnaround gate
 * turns per-slot read and write requests into same-cycle permits
 * from per-rank tWTR windows, the tRTW counter and the starvation guard
 */

`timescale 1ns/10ps

module mc_rw_turnaround #(
  parameter int NUM_RANKS = 4,
  parameter int T_WTR_L   = 9,
  parameter int T_WTR_S   = 3,
  parameter int T_RTW     = 4,
  parameter int STARVE_W  = 9,
  parameter bit STARVE_EN = 1'b1,
  // rank select width
  localparam int RK_W = (NUM_RANKS > 1) ? $clog2(NUM_RANKS) : 1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  mc_rw_pkg::slot_vec_t rd_req,
  input  mc_rw_pkg::slot_vec_t wr_req,
  input  mc_rw_pkg::bg_t       cmd_group [mc_rw_pkg::NUM_SLOTS],
  input  logic [RK_W-1:0]      cmd_rank [mc_rw_pkg::NUM_SLOTS],
  // CAS strobes for the command issued this cycle
  input  logic                 rd_cas,
  input  logic                 wr_cas,
  // target of the winning write
  input  mc_rw_pkg::bg_t       win_group,
  input  logic [RK_W-1:0]      win_rank,
  output mc_rw_pkg::slot_vec_t rd_permit,
  output mc_rw_pkg::slot_vec_t wr_permit
);

  import mc_rw_pkg::*;

  // requests after the starvation guard
  slot_vec_t rd_req_ok;
  slot_vec_t wr_req_ok;

  // per-rank WTR state
  logic [NUM_RANKS-1:0] wr_cas_rank;
  logic [NUM_RANKS-1:0] ok_long;
  logic [NUM_RANKS-1:0] ok_short;
  bg_t                  last_group [NUM_RANKS];

  // ----------------------------------------------------------------------
  // starvation guard
  // ----------------------------------------------------------------------

  mc_rw_starve #(
    .STARVE_W  (STARVE_W),
    .STARVE_EN (STARVE_EN)
  ) u_starve (
    .clk       (clk),
    .rst       (rst),
    .rd_req    (rd_req),
    .wr_req    (wr_req),
    .rd_req_ok (rd_req_ok),
    .wr_req_ok (wr_req_ok)
  );

  // ----------------------------------------------------------------------
  // write-to-read timers, one per rank
  // ----------------------------------------------------------------------

  for (genvar g = 0; g < NUM_RANKS; g++) begin : g_wtr
    // only the addressed rank sees the write
    assign wr_cas_rank[g] = wr_cas && (win_rank == RK_W'(g));

    mc_wtr_timer #(
      .T_WTR_L (T_WTR_L),
      .T_WTR_S (T_WTR_S)
    ) u_wtr (
      .clk        (clk),
      .rst        (rst),
      .wr_cas     (wr_cas_rank[g]),
      .win_group  (win_group),
      .last_group (last_group[g]),
      .ok_long    (ok_long[g]),
      .ok_short   (ok_short[g])
    );
  end

  // ----------------------------------------------------------------------
  // read gate
  // ----------------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (!rd_req_ok[i]) begin
        rd_permit[i] = 1'b0;
      end else if (last_group[cmd_rank[i]] == cmd_group[i]) begin
        // same bank group as the last write, long window
        rd_permit[i] = ok_long[cmd_rank[i]];
      end else begin
        // other group of the rank, short window
        rd_permit[i] = ok_short[cmd_rank[i]];
      end
    end
  end

  // ----------------------------------------------------------------------
  // write gate
  // ----------------------------------------------------------------------

  mc_rtw_timer #(
    .T_RTW (T_RTW)
  ) u_rtw (
    .clk       (clk),
    .rst       (rst),
    .rd_cas    (rd_cas),
    .wr_req    (wr_req_ok),
    .wr_permit (wr_permit)
  );

endmodule

//--- mc_wtr_timer.sv
/*
 * write-to-read timer for one rank
 * records the bank group of the last write CAS to the rank and
 * runs the long (same group) and short (other group) tWTR windows
 */

`timescale 1ns/10ps

module mc_wtr_timer #(
  parameter int T_WTR_L = 9,
  parameter int T_WTR_S = 3
) (
  input  logic            clk,
  input  logic            rst,
  // write CAS already qualified with this rank
  input  logic            wr_cas,
  input  mc_rw_pkg::bg_t  win_group,
  output mc_rw_pkg::bg_t  last_group,
  output logic            ok_long,
  output logic            ok_short
);

  import mc_rw_pkg::*;

  // ----------------------------------------------------------------------
  // window lengths in fabric cycles
  // ----------------------------------------------------------------------

  localparam int L_LOAD = ck_to_fabric(T_WTR_L);
  localparam int S_LOAD = ck_to_fabric(T_WTR_S);
  localparam int MAX_LOAD = (L_LOAD > S_LOAD) ? L_LOAD : S_LOAD;
  // one counter width shared by both windows
  localparam int CNT_W = (MAX_LOAD > 0) ? $clog2(MAX_LOAD + 1) : 1;

  logic [CNT_W-1:0] cnt_long;
  logic [CNT_W-1:0] cnt_short;
  bg_t              group_q;

  // ----------------------------------------------------------------------
  // countdowns
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst) begin
      cnt_long  <= '0;
      cnt_short <= '0;
      group_q   <= '0;
    end else if (wr_cas) begin
      // new write restarts both windows
      cnt_long  <= CNT_W'(L_LOAD);
      cnt_short <= CNT_W'(S_LOAD);
      group_q   <= win_group;
    end else begin
      // count down and park at zero
      if (cnt_long != '0) begin
        cnt_long <= cnt_long - 1'b1;
      end
      if (cnt_short != '0) begin
        cnt_short <= cnt_short - 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // read permits for this rank
  // ----------------------------------------------------------------------

  // a write in this cycle closes both windows at once
  assign ok_long  = (cnt_long == '0) && !wr_cas;
  assign ok_short = (cnt_short == '0) && !wr_cas;

  // group compare happens in the top per slot
  assign last_group = group_q;

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the turnaround gate testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
# a build error or an aborted run counts as a failure
{ verilator --binary --timing --assert --top-module mc_rw_tb -f list.f -o vsim \
  && ./obj_dir/vsim; } > sim.log 2>&1 || echo "Test failed" >> sim.log
grep -q "Test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } || { echo "PASS"; exit 0; }

//--- tb_clk_gen.sv
/*
 * testbench clock and reset source
 * 10 ns clock, active-low reset held for the first 4 rising edges
 */

`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  // free running, 5 ns per half period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // synchronous release on a rising edge
  initial begin
    rst = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b1;
  end

endmodule
